// ==== bench/spi_tests.txt ====
// op: 1 write, 2 read, 3 poll until idle, 4 transfer, 5 held write, 6 held read, 7 random
// columns: op address strobe wdata resp rdata, resp 0 is okay and 2 is slverr, op 0 ends
// register access after reset
2 20010004 0 00000000 0 00000000
1 20010000 f 00000007 0 00000000
2 20010000 0 00000000 0 00000007
1 20010010 f 0000003c 0 00000000
2 20010010 0 00000000 0 0000003c
1 20010010 f 00000001 0 00000000
// loopback in every mode, ctrl bit 0 cpol, bit 1 cpha, bit 2 lsb first
1 20010000 f 00000000 0 00000000
4 2001000c 1 123456a5 0 000000a5
1 20010000 f 00000001 0 00000000
4 2001000c 3 1234c3b7 0 0000c3b7
1 20010000 f 00000002 0 00000000
4 2001000c f deadbeef 0 deadbeef
1 20010000 f 00000003 0 00000000
4 2001000c 1 0000015a 0 0000005a
1 20010000 f 00000004 0 00000000
4 2001000c 3 00ab9001 0 00009001
1 20010000 f 00000005 0 00000000
4 2001000c f 80000001 0 80000001
1 20010000 f 00000006 0 00000000
4 2001000c 1 ff00ff3c 0 0000003c
1 20010000 f 00000007 0 00000000
4 2001000c f 13579bdf 0 13579bdf
7 2001000c 1 00000000 0 00000000
7 2001000c 3 00000000 0 00000000
7 2001000c f 00000000 0 00000000
// access errors
2 2001000c 0 00000000 2 00000000
1 20010004 f 00000001 2 00000000
2 20020004 0 00000000 2 00000000
1 2001000c 5 000000aa 2 00000000
// busy rejection
1 2001000c f 11223344 0 00000000
1 2001000c f 55667788 2 00000000
1 20010000 f 00000000 2 00000000
3 20010004 0 00000000 0 00000000
2 20010004 0 00000000 0 00000002
2 20010008 0 00000000 0 11223344
2 20010000 0 00000000 0 00000007
// back-pressure
5 20010010 f 00000002 0 00000000
6 20010010 0 00000000 0 00000002
0 00000000 0 00000000 0 00000000

// ==== flist.f ====
source/spi_pkg.sv
source/spi_axi_ctrl.sv
source/spi_regs.sv
source/spi_shifter.sv
source/spi_top.sv
bench/spi_top_tb.sv

// ==== bench/spi_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_top_tb import spi_pkg::*; ();

   localparam int clk_half    = 20;
   localparam int wait_limit  = 200;
   localparam int poll_limit  = 2000;
   localparam int hold_cycles = 6;
   localparam int max_tests   = 64;

   logic        clk;
   logic        rstn;
   logic [31:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic        bvalid;
   logic [1:0]  bresp;
   logic        bready;
   logic [31:0] araddr;
   logic        arvalid;
   logic        arready;
   logic        rvalid;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rready;
   wire         sclk;
   wire         mosi;
   wire         cs_n;

   // six words per test line
   logic [31:0] test_mem [0:6*max_tests-1];
   logic [31:0] rng_state;
   int          pass_count;
   int          fail_count;
   logic        test_bad;
   logic        run_aborted;
   // idle level of sclk, follows the last accepted control write
   logic        ctrl_cpol;

   // mosi loops straight back into miso
   spi_top i_spi_top (
      .s_axi_aclk_i    (clk),
      .s_axi_aresetn_i (rstn),
      .s_axi_awaddr_i  (awaddr),
      .s_axi_awvalid_i (awvalid),
      .s_axi_awready_o (awready),
      .s_axi_wdata_i   (wdata),
      .s_axi_wstrb_i   (wstrb),
      .s_axi_wvalid_i  (wvalid),
      .s_axi_wready_o  (wready),
      .s_axi_bvalid_o  (bvalid),
      .s_axi_bresp_o   (bresp),
      .s_axi_bready_i  (bready),
      .s_axi_araddr_i  (araddr),
      .s_axi_arvalid_i (arvalid),
      .s_axi_arready_o (arready),
      .s_axi_rvalid_o  (rvalid),
      .s_axi_rdata_o   (rdata),
      .s_axi_rresp_o   (rresp),
      .s_axi_rready_i  (rready),
      .spi_sclk_o      (sclk),
      .spi_mosi_o      (mosi),
      .spi_cs_n_o      (cs_n),
      .spi_miso_i      (mosi)
   );

   always #clk_half clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // loopback returns only the bytes selected by the strobe
   function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
      case (strb)
         4'b0001: return 32'h0000_00ff;
         4'b0011: return 32'h0000_ffff;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic bus_flag(input int sel);
      case (sel)
         0:       return awready;
         1:       return bvalid;
         2:       return arready;
         3:       return rvalid;
         default: return !cs_n;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
         test_bad = 1'b1;
      end
   endtask

   // outputs are looked at on the falling edge, half a cycle after they settle
   task automatic wait_flag(input int sel, input string name);
      int n;
      n = 0;
      @(negedge clk);
      while (!bus_flag(sel) && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (!bus_flag(sel)) begin
         $display("timeout while waiting for %s", name);
         test_bad    = 1'b1;
         run_aborted = 1'b1;
      end
   endtask

   // handshakes low, chip select released and the clock parked at cpol
   task automatic check_reset_state();
      check_value("awready", awready, 1'b0);
      check_value("wready", wready, 1'b0);
      check_value("arready", arready, 1'b0);
      check_value("bvalid", bvalid, 1'b0);
      check_value("rvalid", rvalid, 1'b0);
      check_value("cs_n", cs_n, 1'b1);
      check_value("sclk", sclk, 1'b0);
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data, output logic [1:0] resp);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      wait_flag(0, "awready");
      check_value("wready", wready, 1'b1);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b1;
      wait_flag(1, "bvalid");
      resp = bresp;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, output logic [1:0] resp,
                           output logic [31:0] data);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      wait_flag(2, "arready");
      @(posedge clk);
      arvalid <= 1'b0;
      wait_flag(3, "rvalid");
      resp = rresp;
      data = rdata;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic wait_idle();
      logic [1:0]  resp;
      logic [31:0] data;
      int          n;
      n    = 0;
      data = 32'h1;
      while (data[0] && n < poll_limit && !run_aborted) begin
         axi_read(spi_base_addr | off_status, resp, data);
         check_value("rresp", resp, resp_okay);
         n++;
      end
      if (data[0] && !run_aborted) begin
         $display("timeout while waiting for busy to clear");
         test_bad    = 1'b1;
         run_aborted = 1'b1;
      end
   endtask

   task automatic run_transfer(input logic [31:0] data, input logic [3:0] strb,
                               input logic [31:0] exp);
      logic [1:0]  resp;
      logic [31:0] got;
      axi_write(spi_base_addr | off_txdata, strb, data, resp);
      check_value("bresp", resp, resp_okay);
      wait_flag(4, "chip select to go low");
      wait_idle();
      @(negedge clk);
      check_value("cs_n", cs_n, 1'b1);
      check_value("sclk", sclk, ctrl_cpol);
      axi_read(spi_base_addr | off_status, resp, got);
      check_value("status", got, 32'h2);
      axi_read(spi_base_addr | off_rxdata, resp, got);
      check_value("rresp", resp, resp_okay);
      check_value("rxdata", got, exp);
      // done is cleared by the receive read
      axi_read(spi_base_addr | off_status, resp, got);
      check_value("status", got, 32'h0);
   endtask

   task automatic held_write(input logic [31:0] addr, input logic [3:0] strb,
                             input logic [31:0] data, input logic [1:0] exp_resp);
      logic [1:0] first;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      bready  <= 1'b0;
      wait_flag(0, "awready");
      // valids stay up, so the same write waits as a second request
      wait_flag(1, "bvalid");
      first = bresp;
      check_value("bresp", first, exp_resp);
      repeat (hold_cycles) begin
         @(negedge clk);
         check_value("bvalid", bvalid, 1'b1);
         check_value("bresp", bresp, first);
         check_value("awready", awready, 1'b0);
      end
      @(posedge clk);
      bready <= 1'b1;
      wait_flag(0, "awready");
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      wait_flag(1, "bvalid");
      check_value("bresp", bresp, exp_resp);
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic held_read(input logic [31:0] addr, input logic [1:0] exp_resp,
                            input logic [31:0] exp_data);
      logic [31:0] first;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b0;
      wait_flag(2, "arready");
      // arvalid stays up, so the same read waits behind the held response
      wait_flag(3, "rvalid");
      first = rdata;
      check_value("rresp", rresp, exp_resp);
      check_value("rdata", first, exp_data);
      repeat (hold_cycles) begin
         @(negedge clk);
         check_value("rvalid", rvalid, 1'b1);
         check_value("rdata", rdata, first);
         check_value("rresp", rresp, exp_resp);
         check_value("arready", arready, 1'b0);
      end
      @(posedge clk);
      rready <= 1'b1;
      wait_flag(2, "arready");
      @(posedge clk);
      arvalid <= 1'b0;
      wait_flag(3, "rvalid");
      check_value("rresp", rresp, exp_resp);
      check_value("rdata", rdata, exp_data);
      @(posedge clk);
      rready <= 1'b0;
      @(negedge clk);
      check_value("rvalid", rvalid, 1'b0);
   endtask

   initial begin : main_seq
      int          idx;
      logic [31:0] op;
      logic [31:0] addr;
      logic [31:0] strb;
      logic [31:0] data;
      logic [31:0] exp_resp;
      logic [31:0] exp_data;
      logic [1:0]  resp;
      logic [31:0] got;
      clk         = 1'b0;
      rstn        = 1'b0;
      awaddr      = 32'h0;
      awvalid     = 1'b0;
      wdata       = 32'h0;
      wstrb       = 4'h0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = 32'h0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      rng_state   = 32'h4e56;
      pass_count  = 0;
      fail_count  = 0;
      test_bad    = 1'b0;
      run_aborted = 1'b0;
      ctrl_cpol   = 1'b0;
      $readmemh("bench/spi_tests.txt", test_mem);
      if ($isunknown(test_mem[0])) begin
         $display("the test file bench/spi_tests.txt could not be read");
         run_aborted = 1'b1;
      end
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      check_reset_state();
      if (test_bad) begin
         fail_count++;
      end else begin
         pass_count++;
      end
      $display("reset state %s", test_bad ? "failed" : "ok");
      idx = 0;
      while (!run_aborted && idx < max_tests && test_mem[6*idx] !== 32'h0) begin
         op       = test_mem[6*idx];
         addr     = test_mem[6*idx+1];
         strb     = test_mem[6*idx+2];
         data     = test_mem[6*idx+3];
         exp_resp = test_mem[6*idx+4];
         exp_data = test_mem[6*idx+5];
         test_bad = 1'b0;
         case (op)
            1: begin
               axi_write(addr, strb[3:0], data, resp);
               check_value("bresp", resp, exp_resp);
               if (addr == (spi_base_addr | off_ctrl) && exp_resp == resp_okay) begin
                  ctrl_cpol = data[0];
               end
            end
            2: begin
               axi_read(addr, resp, got);
               check_value("rresp", resp, exp_resp);
               check_value("rdata", got, exp_data);
            end
            3: wait_idle();
            4: run_transfer(data, strb[3:0], exp_data);
            5: held_write(addr, strb[3:0], data, exp_resp[1:0]);
            6: held_read(addr, exp_resp[1:0], exp_data);
            7: begin
               rng_state = lcg_next(rng_state);
               run_transfer(rng_state, strb[3:0], rng_state & strobe_mask(strb[3:0]));
            end
            default: begin
               $display("test %0d has an unknown operation code %0h", idx, op);
               test_bad    = 1'b1;
               run_aborted = 1'b1;
            end
         endcase
         if (test_bad) begin
            fail_count++;
         end else begin
            pass_count++;
         end
         $display("test %0d op %0h addr 0x%08h %s", idx, op, addr,
                  test_bad ? "failed" : "ok");
         idx++;
      end
      $display("tests %0d passed %0d failed %0d", pass_count + fail_count,
               pass_count, fail_count);
      if (fail_count == 0 && !run_aborted) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/spi_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_top import spi_pkg::*; (
   input  wire          s_axi_aclk_i,
   input  wire          s_axi_aresetn_i,
   input  wire [31:0]   s_axi_awaddr_i,
   input  wire          s_axi_awvalid_i,
   output logic         s_axi_awready_o,
   input  wire [31:0]   s_axi_wdata_i,
   input  wire [3:0]    s_axi_wstrb_i,
   input  wire          s_axi_wvalid_i,
   output logic         s_axi_wready_o,
   output logic         s_axi_bvalid_o,
   output logic [1:0]   s_axi_bresp_o,
   input  wire          s_axi_bready_i,
   input  wire [31:0]   s_axi_araddr_i,
   input  wire          s_axi_arvalid_i,
   output logic         s_axi_arready_o,
   output logic         s_axi_rvalid_o,
   output logic [31:0]  s_axi_rdata_o,
   output logic [1:0]   s_axi_rresp_o,
   input  wire          s_axi_rready_i,
   output logic         spi_sclk_o,
   output logic         spi_mosi_o,
   output logic         spi_cs_n_o,
   input  wire          spi_miso_i
);

   spi_req_t    req;
   logic [31:0] reg_rdata;
   logic        reg_reject;
   spi_cfg_t    cfg;
   spi_xfer_t   xfer;
   spi_stat_t   stat;
   logic        rx_done;
   logic [31:0] rx_data;

   // bus front end
   spi_axi_ctrl i_spi_axi_ctrl (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wstrb_i   (s_axi_wstrb_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .s_axi_bresp_o   (s_axi_bresp_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_rresp_o   (s_axi_rresp_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .reg_rdata_i     (reg_rdata),
      .reg_reject_i    (reg_reject),
      .req_o           (req)
   );

   spi_regs i_spi_regs (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .req_i           (req),
      .stat_i          (stat),
      .rx_done_i       (rx_done),
      .rx_data_i       (rx_data),
      .rdata_o         (reg_rdata),
      .reject_o        (reg_reject),
      .cfg_o           (cfg),
      .xfer_o          (xfer)
   );

   // serial engine on the pins
   spi_shifter i_spi_shifter (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .cfg_i           (cfg),
      .xfer_i          (xfer),
      .spi_miso_i      (spi_miso_i),
      .spi_sclk_o      (spi_sclk_o),
      .spi_mosi_o      (spi_mosi_o),
      .spi_cs_n_o      (spi_cs_n_o),
      .stat_o          (stat),
      .rx_done_o       (rx_done),
      .rx_data_o       (rx_data)
   );

endmodule

`default_nettype wire

// ==== source/spi_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_shifter import spi_pkg::*; (
   input  wire             s_axi_aclk_i,
   input  wire             s_axi_aresetn_i,
   input  wire spi_cfg_t   cfg_i,
   input  wire spi_xfer_t  xfer_i,
   input  wire             spi_miso_i,
   output logic            spi_sclk_o,
   output logic            spi_mosi_o,
   output logic            spi_cs_n_o,
   output spi_stat_t       stat_o,
   output logic            rx_done_o,
   output logic [31:0]     rx_data_o
);

   logic        busy_q;
   logic        done_q;
   logic        cs_n_q;
   logic        sclk_q;
   logic        mosi_q;
   logic        rx_done_q;
   logic [7:0]  div_cnt_q;
   logic [6:0]  edge_cnt_q;
   logic [5:0]  nbits_q;
   logic [31:0] tx_sh_q;
   logic [31:0] rx_sh_q;
   logic [31:0] rx_data_q;

   logic [5:0]  nbits_w;
   logic [31:0] tx_load;
   logic        launch;
   logic        tick;
   logic        last_phase;
   logic        sample_now;

   function automatic logic out_bit(input logic [31:0] w, input logic lsb);
      return lsb ? w[0] : w[31];
   endfunction

   function automatic logic [31:0] shift_out(input logic [31:0] w, input logic lsb);
      return lsb ? {1'b0, w[31:1]} : {w[30:0], 1'b0};
   endfunction

   always_comb begin
      case (xfer_i.len)
         len_1b:  nbits_w = 6'd8;
         len_2b:  nbits_w = 6'd16;
         default: nbits_w = 6'd32;
      endcase
   end

   // msb first sends from bit 31, so the word is moved to the top
   assign tx_load = cfg_i.lsb_first ? xfer_i.data : xfer_i.data << (6'd32 - nbits_w);

   assign launch     = ~busy_q & xfer_i.start;
   assign tick       = div_cnt_q == cfg_i.div;
   assign last_phase = edge_cnt_q == {nbits_q, 1'b0};
   // cpha 0 samples on leading edges, cpha 1 on trailing ones
   assign sample_now = edge_cnt_q[0] == cfg_i.cpha;

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         busy_q     <= 1'b0;
         done_q     <= 1'b0;
         cs_n_q     <= 1'b1;
         sclk_q     <= 1'b0;
         mosi_q     <= 1'b0;
         rx_done_q  <= 1'b0;
         div_cnt_q  <= '0;
         edge_cnt_q <= '0;
      end else begin
         rx_done_q <= 1'b0;
         if (!busy_q) begin
            sclk_q <= cfg_i.cpol;
            if (launch) begin
               busy_q     <= 1'b1;
               done_q     <= 1'b0;
               cs_n_q     <= 1'b0;
               div_cnt_q  <= '0;
               edge_cnt_q <= '0;
               // with cpha 0 the first bit must be on the line before the first edge
               if (!cfg_i.cpha) begin
                  mosi_q <= out_bit(tx_load, cfg_i.lsb_first);
               end
            end
         end else if (!tick) begin
            div_cnt_q <= div_cnt_q + 8'd1;
         end else begin
            div_cnt_q <= '0;
            if (last_phase) begin
               // one idle half period after the last edge, then release cs_n
               busy_q    <= 1'b0;
               done_q    <= 1'b1;
               cs_n_q    <= 1'b1;
               rx_done_q <= 1'b1;
            end else begin
               sclk_q     <= ~sclk_q;
               edge_cnt_q <= edge_cnt_q + 7'd1;
               if (!sample_now) begin
                  mosi_q <= out_bit(tx_sh_q, cfg_i.lsb_first);
               end
            end
         end
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (launch) begin
         nbits_q <= nbits_w;
         rx_sh_q <= '0;
         tx_sh_q <= cfg_i.cpha ? tx_load : shift_out(tx_load, cfg_i.lsb_first);
      end else if (busy_q && tick && !last_phase) begin
         if (sample_now) begin
            rx_sh_q <= cfg_i.lsb_first ? {spi_miso_i, rx_sh_q[31:1]}
                                       : {rx_sh_q[30:0], spi_miso_i};
         end else begin
            tx_sh_q <= shift_out(tx_sh_q, cfg_i.lsb_first);
         end
      end
      // lsb first fills from the top, pull it down to bit 0
      if (busy_q && tick && last_phase) begin
         rx_data_q <= cfg_i.lsb_first ? rx_sh_q >> (6'd32 - nbits_q) : rx_sh_q;
      end
   end

   assign spi_sclk_o = sclk_q;
   assign spi_mosi_o = mosi_q;
   assign spi_cs_n_o = cs_n_q;
   assign stat_o     = '{busy: busy_q, done: done_q};
   assign rx_done_o  = rx_done_q;
   assign rx_data_o  = rx_data_q;

   a_cs_during_busy: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      stat_o.busy |-> !spi_cs_n_o)
      else $error("chip select released during a transfer");

endmodule

`default_nettype wire

// ==== source/spi_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_regs import spi_pkg::*; (
   input  wire            s_axi_aclk_i,
   input  wire            s_axi_aresetn_i,
   input  wire spi_req_t  req_i,
   input  wire spi_stat_t stat_i,
   input  wire            rx_done_i,
   input  wire [31:0]     rx_data_i,
   output logic [31:0]    rdata_o,
   output logic           reject_o,
   output spi_cfg_t       cfg_o,
   output spi_xfer_t      xfer_o
);

   spi_cfg_word_u ctrl_q;
   spi_cfg_word_u div_q;
   spi_cfg_word_u wr_word;
   logic [31:0]   tx_q;
   spi_len_e      len_q;
   logic          start_q;
   logic [31:0]   rx_q;
   logic          done_q;
   logic          busy_w;
   logic          wr_ok;
   logic          rd_rx;

   // launch cycle and capture cycle both count as busy
   assign busy_w   = stat_i.busy | start_q | rx_done_i;
   assign reject_o = req_i.valid & req_i.write & busy_w;
   assign wr_ok    = req_i.valid & req_i.write & ~busy_w;
   assign rd_rx    = req_i.valid & ~req_i.write & (req_i.offset == off_rxdata);
   assign wr_word  = req_i.wdata;

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         ctrl_q.raw <= '0;
         div_q.raw  <= '0;
         start_q    <= 1'b0;
         done_q     <= 1'b0;
      end else begin
         start_q <= 1'b0;
         if (wr_ok) begin
            case (req_i.offset)
               off_ctrl: ctrl_q.ctrl <= '{rsvd: '0,
                                          lsb_first: wr_word.ctrl.lsb_first,
                                          cpha: wr_word.ctrl.cpha,
                                          cpol: wr_word.ctrl.cpol};
               off_div:    div_q.raw <= {24'h0, wr_word.raw[7:0]};
               off_txdata: start_q   <= 1'b1;
               default: ;
            endcase
         end
         // sticky until the received word is read
         if (rx_done_i) begin
            done_q <= 1'b1;
         end else if (rd_rx) begin
            done_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (wr_ok && req_i.offset == off_txdata) begin
         tx_q  <= req_i.wdata;
         len_q <= req_i.len;
      end
      if (rx_done_i) begin
         rx_q <= rx_data_i;
      end
   end

   // engine done drops on a new start, so a stale flag is hidden
   always_comb begin
      case (req_i.offset)
         off_ctrl:   rdata_o = ctrl_q.raw;
         off_status: rdata_o = {30'h0, done_q & stat_i.done, stat_i.busy | rx_done_i};
         off_rxdata: rdata_o = rx_q;
         off_div:    rdata_o = div_q.raw;
         default:    rdata_o = 32'h0;
      endcase
   end

   assign cfg_o = '{cpol: ctrl_q.ctrl.cpol,
                    cpha: ctrl_q.ctrl.cpha,
                    lsb_first: ctrl_q.ctrl.lsb_first,
                    div: div_q.raw[7:0]};

   assign xfer_o = '{start: start_q, data: tx_q, len: len_q};

   a_start_idle: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      xfer_o.start |-> !stat_i.busy)
      else $error("transfer launched while the shifter is busy");

endmodule

`default_nettype wire

// ==== source/spi_axi_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_axi_ctrl import spi_pkg::*; (
   input  wire          s_axi_aclk_i,
   input  wire          s_axi_aresetn_i,
   input  wire [31:0]   s_axi_awaddr_i,
   input  wire          s_axi_awvalid_i,
   output logic         s_axi_awready_o,
   input  wire [31:0]   s_axi_wdata_i,
   input  wire [3:0]    s_axi_wstrb_i,
   input  wire          s_axi_wvalid_i,
   output logic         s_axi_wready_o,
   output logic         s_axi_bvalid_o,
   output logic [1:0]   s_axi_bresp_o,
   input  wire          s_axi_bready_i,
   input  wire [31:0]   s_axi_araddr_i,
   input  wire          s_axi_arvalid_i,
   output logic         s_axi_arready_o,
   output logic         s_axi_rvalid_o,
   output logic [31:0]  s_axi_rdata_o,
   output logic [1:0]   s_axi_rresp_o,
   input  wire          s_axi_rready_i,
   input  wire [31:0]   reg_rdata_i,
   input  wire          reg_reject_i,
   output spi_req_t     req_o
);

   logic        rd_acc;
   logic        wr_acc;
   logic        rd_legal;
   logic        wr_legal;
   logic        len_ok;
   spi_len_e    wr_len;
   logic [7:0]  rd_low;
   logic [7:0]  wr_low;

   logic        bvalid_q;
   logic [1:0]  bresp_q;
   logic        rvalid_q;
   logic [1:0]  rresp_q;
   logic [31:0] rdata_q;

   function automatic logic hit(input logic [7:0] low, input logic [4:0] off);
      return low == {3'b000, off};
   endfunction

   // one request per cycle, a read wins when both channels arrive together
   assign rd_acc = s_axi_arvalid_i & ~rvalid_q;
   assign wr_acc = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_q & ~rd_acc;

   assign s_axi_arready_o = rd_acc;
   assign s_axi_awready_o = wr_acc;
   assign s_axi_wready_o  = wr_acc;

   assign rd_low = s_axi_araddr_i[7:0];
   assign wr_low = s_axi_awaddr_i[7:0];

   // strobe to transfer length
   always_comb begin
      len_ok = 1'b1;
      case (s_axi_wstrb_i)
         4'b0001: wr_len = len_1b;
         4'b0011: wr_len = len_2b;
         4'b1111: wr_len = len_4b;
         default: begin
            wr_len = len_4b;
            len_ok = 1'b0;
         end
      endcase
   end

   // txdata is write only, status and rxdata are read only
   assign rd_legal = ((s_axi_araddr_i & ~spi_mask_addr) == spi_base_addr) &
                     (hit(rd_low, off_ctrl) | hit(rd_low, off_status) |
                      hit(rd_low, off_rxdata) | hit(rd_low, off_div));

   assign wr_legal = ((s_axi_awaddr_i & ~spi_mask_addr) == spi_base_addr) &
                     (hit(wr_low, off_ctrl) | hit(wr_low, off_div) |
                      (hit(wr_low, off_txdata) & len_ok));

   // illegal accesses stay here and never strobe the register file
   always_comb begin
      req_o = '0;
      if (rd_acc) begin
         req_o.valid  = rd_legal;
         req_o.offset = s_axi_araddr_i[4:0];
      end else if (wr_acc) begin
         req_o.valid  = wr_legal;
         req_o.write  = 1'b1;
         req_o.offset = s_axi_awaddr_i[4:0];
         req_o.wdata  = s_axi_wdata_i;
         req_o.len    = wr_len;
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_acc) begin
            bvalid_q <= 1'b1;
         end else if (s_axi_bready_i) begin
            bvalid_q <= 1'b0;
         end
         if (rd_acc) begin
            rvalid_q <= 1'b1;
         end else if (s_axi_rready_i) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // response payload is loaded on acceptance and held until taken
   always_ff @(posedge s_axi_aclk_i) begin
      if (wr_acc) begin
         bresp_q <= (wr_legal && !reg_reject_i) ? resp_okay : resp_slverr;
      end
      if (rd_acc) begin
         rresp_q <= rd_legal ? resp_okay : resp_slverr;
         rdata_q <= rd_legal ? reg_rdata_i : 32'h0;
      end
   end

   assign s_axi_bvalid_o = bvalid_q;
   assign s_axi_bresp_o  = bresp_q;
   assign s_axi_rvalid_o = rvalid_q;
   assign s_axi_rresp_o  = rresp_q;
   assign s_axi_rdata_o  = rdata_q;

   a_bvalid_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_bresp_o))
      else $error("write response dropped before bready");

   a_rvalid_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
      else $error("read response changed before rready");

   a_no_req_pending: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      req_o.valid |-> !(req_o.write ? s_axi_bvalid_o : s_axi_rvalid_o))
      else $error("register request issued with its response still pending");

endmodule

`default_nettype wire

// ==== source/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

   // the peripheral answers in a 256 byte window
   localparam logic [31:0] spi_base_addr = 32'h2001_0000;
   localparam logic [31:0] spi_mask_addr = 32'h0000_00FF;

   // register offsets, low five address bits
   localparam logic [4:0] off_ctrl   = 5'h00;
   localparam logic [4:0] off_status = 5'h04;
   localparam logic [4:0] off_rxdata = 5'h08;
   localparam logic [4:0] off_txdata = 5'h0C;
   localparam logic [4:0] off_div    = 5'h10;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // encoding follows wstrb bits 3 and 1
   typedef enum logic [1:0] {
      len_1b = 2'b00,
      len_2b = 2'b01,
      len_4b = 2'b11
   } spi_len_e;

   // control register layout, cpol is bit 0
   typedef struct packed {
      logic [28:0] rsvd;
      logic        lsb_first;
      logic        cpha;
      logic        cpol;
   } spi_ctrl_t;

   // one configuration word, read as plain bits or as control fields
   typedef union packed {
      logic [31:0] raw;
      spi_ctrl_t   ctrl;
   } spi_cfg_word_u;

   typedef struct packed {
      logic        valid;
      logic        write;
      logic [4:0]  offset;
      logic [31:0] wdata;
      spi_len_e    len;
   } spi_req_t;

   typedef struct packed {
      logic       cpol;
      logic       cpha;
      logic       lsb_first;
      logic [7:0] div;
   } spi_cfg_t;

   typedef struct packed {
      logic        start;
      logic [31:0] data;
      spi_len_e    len;
   } spi_xfer_t;

   typedef struct packed {
      logic busy;
      logic done;
   } spi_stat_t;

endpackage

`default_nettype wire
